// File: include/s_cpu_consts.svh
// ==========================================================
// fixed widths and constants of the reduced SPC700 step
// state and instruction codes are 6 bits wide
// ==========================================================

`ifndef S_CPU_CONSTS_SVH
`define S_CPU_CONSTS_SVH

// datapath widths
`define S_DATA_W 8
`define S_ADDR_W 16

// pc value after reset
`define S_RESET_PC 16'hFFC0

// direct page high byte, P clear / P set
`define S_DP_PAGE0 8'h00
`define S_DP_PAGE1 8'h01

// encoding widths
`define S_STATE_W 6
`define S_INSTR_W 6

`endif

// File: hw/s_isa_pkg.sv
// ==========================================================
// architectural types: control states, instructions, PSW
// only the reduced state and instruction set is encoded
// ==========================================================

`include "s_cpu_consts.svh"

package s_isa_pkg;

    typedef enum logic [`S_STATE_W-1:0] {
        SS_IDLE = 0,
        SS_ADLFETCH,
        SS_ADHFETCH,
        SS_CALC_REG1_MEMPC,
        SS_CALC_REG1_MEMDP,
        SS_CALC_REG1_MEMABS,
        SS_COPY_MEMDP_REG1,
        SS_CALC_REG1,
        SS_XCN_REG1,
        SS_PSW_CHANGE
    } state_e;

    typedef enum logic [`S_INSTR_W-1:0] {
        SI_MOV, SI_ADC, SI_ADD, SI_SBC, SI_SUB,
        SI_CMP, SI_AND, SI_OR, SI_EOR,
        SI_INC, SI_DEC, SI_ASL, SI_LSR, SI_ROL, SI_ROR,
        SI_CLRC, SI_SETC, SI_NOTC, SI_CLRV,
        SI_CLRP, SI_SETP, SI_EI, SI_DI
    } instr_e;

    // bit 7 down to bit 0
    typedef struct packed {
        logic n;
        logic v;
        logic p;
        logic b;
        logic h;
        logic i;
        logic z;
        logic c;
    } psw_flags_t;

    // flag set in the register, write mask in the decoder
    typedef union packed {
        logic [7:0] raw;
        psw_flags_t f;
    } psw_word_u;

endpackage

// File: hw/s_ctl_pkg.sv
// ==========================================================
// control encodings passed from the decoders to the
// execution unit, one set per clock
// ==========================================================

package s_ctl_pkg;

    // memory address source
    typedef enum logic [1:0] {MA_PC, MA_DP, MA_ABS} addr_src_e;

    // alu operand sources
    typedef enum logic [1:0] {AA_REG1, AA_RD, AA_REG1_XCN} a_src_e;
    typedef enum logic [1:0] {AB_0, AB_1, AB_RD} b_src_e;

    typedef enum logic [3:0] {
        ADD, ADC, SUB, SBC,
        AND, OR, EOR,
        ASL, LSR, ROL, ROR
    } alu_op_e;

    // psw write data source
    typedef enum logic [1:0] {PW_ALUF, PW_0, PW_FF, PW_NOTC} psw_src_e;

    typedef struct packed {
        addr_src_e addr_src;
        logic mem_read;
        logic mem_write;
        logic pc_inc;
        logic adl_write;
        logic adh_write;
        logic reg1_write;
    } xfer_ctl_t;

    typedef struct packed {
        a_src_e a_src;
        b_src_e b_src;
        alu_op_e op;
        psw_src_e psw_src;
        s_isa_pkg::psw_word_u psw_write;
    } alu_ctl_t;

endpackage

// File: hw/s_transfer_decoder.sv
// ==========================================================
// memory strobes, address source and register transfers
// purely combinational, one control state per clock
// ==========================================================

`timescale 1ns/1ps

module s_transfer_decoder (
    input  s_isa_pkg::state_e    state,
    input  s_isa_pkg::instr_e    instr,
    output s_ctl_pkg::xfer_ctl_t xfer_ctl
);

    always_comb begin
        xfer_ctl = '0;
        xfer_ctl.addr_src = s_ctl_pkg::MA_PC;

        case (state)
            s_isa_pkg::SS_ADLFETCH, s_isa_pkg::SS_ADHFETCH: begin
                // addr byte <- mem[pc++]
                xfer_ctl.mem_read = 1'b1;
                xfer_ctl.pc_inc = 1'b1;
                xfer_ctl.adl_write = (state == s_isa_pkg::SS_ADLFETCH);
                xfer_ctl.adh_write = (state == s_isa_pkg::SS_ADHFETCH);
            end
            s_isa_pkg::SS_CALC_REG1_MEMPC: begin
                xfer_ctl.mem_read = 1'b1;
                xfer_ctl.pc_inc = 1'b1;
                xfer_ctl.reg1_write = (instr != s_isa_pkg::SI_CMP);
            end
            s_isa_pkg::SS_CALC_REG1_MEMDP: begin
                xfer_ctl.addr_src = s_ctl_pkg::MA_DP;
                xfer_ctl.mem_read = 1'b1;
                xfer_ctl.reg1_write = (instr != s_isa_pkg::SI_CMP);
            end
            s_isa_pkg::SS_CALC_REG1_MEMABS: begin
                xfer_ctl.addr_src = s_ctl_pkg::MA_ABS;
                xfer_ctl.mem_read = 1'b1;
                xfer_ctl.reg1_write = (instr != s_isa_pkg::SI_CMP);
            end
            s_isa_pkg::SS_COPY_MEMDP_REG1: begin
                // mem[dp] <- reg1
                xfer_ctl.addr_src = s_ctl_pkg::MA_DP;
                xfer_ctl.mem_write = 1'b1;
            end
            s_isa_pkg::SS_CALC_REG1, s_isa_pkg::SS_XCN_REG1: begin
                xfer_ctl.reg1_write = (instr != s_isa_pkg::SI_CMP);
            end
            default: ;
        endcase
    end

endmodule

// File: hw/s_alu_decoder.sv
// ==========================================================
// alu operation, operand sources and psw write mask
// NOTC only selects its source, the inverse is formed later
// ==========================================================

`timescale 1ns/1ps

module s_alu_decoder (
    input  s_isa_pkg::state_e   state,
    input  s_isa_pkg::instr_e   instr,
    output s_ctl_pkg::alu_ctl_t alu_ctl
);

    always_comb begin
        // default is reg1 + 0 with no flag written
        alu_ctl.a_src = s_ctl_pkg::AA_REG1;
        alu_ctl.b_src = s_ctl_pkg::AB_0;
        alu_ctl.op = s_ctl_pkg::ADD;
        alu_ctl.psw_src = s_ctl_pkg::PW_ALUF;
        alu_ctl.psw_write.raw = '0;

        case (state)
            s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SS_CALC_REG1_MEMDP,
            s_isa_pkg::SS_CALC_REG1_MEMABS: begin
                if (instr == s_isa_pkg::SI_MOV) begin
                    alu_ctl.a_src = s_ctl_pkg::AA_RD;
                end else begin
                    alu_ctl.b_src = s_ctl_pkg::AB_RD;
                end

                case (instr)
                    s_isa_pkg::SI_ADC: alu_ctl.op = s_ctl_pkg::ADC;
                    s_isa_pkg::SI_SBC: alu_ctl.op = s_ctl_pkg::SBC;
                    s_isa_pkg::SI_SUB, s_isa_pkg::SI_CMP: alu_ctl.op = s_ctl_pkg::SUB;
                    s_isa_pkg::SI_AND: alu_ctl.op = s_ctl_pkg::AND;
                    s_isa_pkg::SI_OR: alu_ctl.op = s_ctl_pkg::OR;
                    s_isa_pkg::SI_EOR: alu_ctl.op = s_ctl_pkg::EOR;
                    default: alu_ctl.op = s_ctl_pkg::ADD;
                endcase

                {alu_ctl.psw_write.f.n, alu_ctl.psw_write.f.z} = 2'b11;
                case (instr)
                    s_isa_pkg::SI_ADC, s_isa_pkg::SI_ADD,
                    s_isa_pkg::SI_SBC, s_isa_pkg::SI_SUB: begin
                        alu_ctl.psw_write.f.v = 1'b1;
                        alu_ctl.psw_write.f.h = 1'b1;
                        alu_ctl.psw_write.f.c = 1'b1;
                    end
                    s_isa_pkg::SI_CMP: alu_ctl.psw_write.f.c = 1'b1;
                    default: ;
                endcase
            end

            s_isa_pkg::SS_CALC_REG1: begin
                // inc/dec and shifts on the accumulator
                alu_ctl.psw_write.f.n = 1'b1;
                alu_ctl.psw_write.f.z = 1'b1;
                alu_ctl.psw_write.f.c = (instr != s_isa_pkg::SI_INC)
                                        && (instr != s_isa_pkg::SI_DEC);
                case (instr)
                    s_isa_pkg::SI_INC: alu_ctl.b_src = s_ctl_pkg::AB_1;
                    s_isa_pkg::SI_DEC: begin
                        alu_ctl.b_src = s_ctl_pkg::AB_1;
                        alu_ctl.op = s_ctl_pkg::SUB;
                    end
                    s_isa_pkg::SI_ASL: alu_ctl.op = s_ctl_pkg::ASL;
                    s_isa_pkg::SI_LSR: alu_ctl.op = s_ctl_pkg::LSR;
                    s_isa_pkg::SI_ROL: alu_ctl.op = s_ctl_pkg::ROL;
                    s_isa_pkg::SI_ROR: alu_ctl.op = s_ctl_pkg::ROR;
                    default: ;
                endcase
            end

            s_isa_pkg::SS_XCN_REG1: begin
                alu_ctl.a_src = s_ctl_pkg::AA_REG1_XCN;
                {alu_ctl.psw_write.f.n, alu_ctl.psw_write.f.z} = 2'b11;
            end

            // ================================================
            // psw change
            // ================================================
            s_isa_pkg::SS_PSW_CHANGE: begin
                case (instr)
                    s_isa_pkg::SI_CLRC, s_isa_pkg::SI_CLRV,
                    s_isa_pkg::SI_CLRP, s_isa_pkg::SI_DI: alu_ctl.psw_src = s_ctl_pkg::PW_0;
                    s_isa_pkg::SI_NOTC: alu_ctl.psw_src = s_ctl_pkg::PW_NOTC;
                    default: alu_ctl.psw_src = s_ctl_pkg::PW_FF;
                endcase
                case (instr)
                    s_isa_pkg::SI_CLRC, s_isa_pkg::SI_SETC,
                    s_isa_pkg::SI_NOTC: alu_ctl.psw_write.f.c = 1'b1;
                    s_isa_pkg::SI_CLRV: begin
                        alu_ctl.psw_write.f.v = 1'b1;
                        alu_ctl.psw_write.f.h = 1'b1;
                    end
                    s_isa_pkg::SI_CLRP, s_isa_pkg::SI_SETP: alu_ctl.psw_write.f.p = 1'b1;
                    s_isa_pkg::SI_EI, s_isa_pkg::SI_DI: alu_ctl.psw_write.f.i = 1'b1;
                    default: ;
                endcase
            end

            // store passes reg1 + 0 through the defaults
            default: ;
        endcase
    end

endmodule

// File: hw/s_alu.sv
// ==========================================================
// 8-bit alu, flags returned in psw bit positions
// p, b and i are always 0 in the flag output
// ==========================================================

`timescale 1ns/1ps

`include "s_cpu_consts.svh"

module s_alu (
    input  logic [`S_DATA_W-1:0] a,
    input  logic [`S_DATA_W-1:0] b,
    input  logic                 carry_in,
    input  s_ctl_pkg::alu_op_e   op,
    output logic [`S_DATA_W-1:0] y,
    output s_isa_pkg::psw_word_u flags
);

    logic                 sub_op;
    logic                 cin;
    logic [`S_DATA_W-1:0] b_eff;
    logic [`S_DATA_W:0]   sum;
    logic [4:0]           half;

    // subtract as a + ~b + carry, carry set means no borrow
    assign sub_op = (op == s_ctl_pkg::SUB) || (op == s_ctl_pkg::SBC);
    assign b_eff = sub_op ? ~b : b;
    assign cin = (op == s_ctl_pkg::ADD) ? 1'b0 :
                 (op == s_ctl_pkg::SUB) ? 1'b1 : carry_in;

    assign sum = {1'b0, a} + {1'b0, b_eff} + {{`S_DATA_W{1'b0}}, cin};
    assign half = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};

    always_comb begin
        flags.raw = '0;
        y = sum[`S_DATA_W-1:0];
        flags.f.c = sum[`S_DATA_W];
        flags.f.h = half[4];
        flags.f.v = (a[7] == b_eff[7]) && (sum[7] != a[7]);

        case (op)
            s_ctl_pkg::AND: y = a & b;
            s_ctl_pkg::OR: y = a | b;
            s_ctl_pkg::EOR: y = a ^ b;
            s_ctl_pkg::ASL: y = {a[6:0], 1'b0};
            s_ctl_pkg::ROL: y = {a[6:0], carry_in};
            s_ctl_pkg::LSR: y = {1'b0, a[7:1]};
            s_ctl_pkg::ROR: y = {carry_in, a[7:1]};
            default: ;
        endcase

        // shifts carry out the bit that leaves
        case (op)
            s_ctl_pkg::AND, s_ctl_pkg::OR, s_ctl_pkg::EOR: flags.f.c = 1'b0;
            s_ctl_pkg::ASL, s_ctl_pkg::ROL: flags.f.c = a[7];
            s_ctl_pkg::LSR, s_ctl_pkg::ROR: flags.f.c = a[0];
            default: ;
        endcase
        if (!sub_op && (op != s_ctl_pkg::ADD) && (op != s_ctl_pkg::ADC)) begin
            flags.f.v = 1'b0;
            flags.f.h = 1'b0;
        end

        flags.f.n = y[7];
        flags.f.z = (y == '0);
    end

endmodule

// File: hw/s_exec_unit.sv
// ==========================================================
// pc, address, accumulator and psw registers
// memory answers in the same cycle, updates land on the edge
// ==========================================================

`timescale 1ns/1ps

`include "s_cpu_consts.svh"

module s_exec_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  s_ctl_pkg::xfer_ctl_t xfer_ctl,
    input  s_ctl_pkg::alu_ctl_t  alu_ctl,
    input  logic [`S_DATA_W-1:0] mem_rdata,
    output logic [`S_ADDR_W-1:0] mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [`S_DATA_W-1:0] mem_wdata,
    output logic [`S_DATA_W-1:0] reg1,
    output s_isa_pkg::psw_word_u psw,
    output logic [`S_ADDR_W-1:0] pc
);

    logic [`S_ADDR_W-1:0] addr_reg;
    logic [`S_DATA_W-1:0] alu_a;
    logic [`S_DATA_W-1:0] alu_b;
    logic [`S_DATA_W-1:0] alu_y;
    logic [7:0]           psw_src_val;
    s_isa_pkg::psw_word_u alu_flags;

    // ==========================================================
    // address and operand selection
    // ==========================================================
    always_comb begin
        case (xfer_ctl.addr_src)
            s_ctl_pkg::MA_DP: begin
                mem_addr = {(psw.f.p ? `S_DP_PAGE1 : `S_DP_PAGE0), addr_reg[7:0]};
            end
            s_ctl_pkg::MA_ABS: mem_addr = addr_reg;
            default: mem_addr = pc;
        endcase

        case (alu_ctl.a_src)
            s_ctl_pkg::AA_RD: alu_a = mem_rdata;
            s_ctl_pkg::AA_REG1_XCN: alu_a = {reg1[3:0], reg1[7:4]};
            default: alu_a = reg1;
        endcase

        case (alu_ctl.b_src)
            s_ctl_pkg::AB_1: alu_b = 8'd1;
            s_ctl_pkg::AB_RD: alu_b = mem_rdata;
            default: alu_b = 8'd0;
        endcase

        case (alu_ctl.psw_src)
            s_ctl_pkg::PW_0: psw_src_val = 8'h00;
            s_ctl_pkg::PW_FF: psw_src_val = 8'hff;
            s_ctl_pkg::PW_NOTC: psw_src_val = {8{~psw.f.c}};
            default: psw_src_val = alu_flags.raw;
        endcase
    end

    assign mem_read = xfer_ctl.mem_read;
    assign mem_write = xfer_ctl.mem_write;
    assign mem_wdata = alu_y;

    s_alu u_alu (
        .a        (alu_a),
        .b        (alu_b),
        .carry_in (psw.f.c),
        .op       (alu_ctl.op),
        .y        (alu_y),
        .flags    (alu_flags)
    );

    // ==========================================================
    // register update
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `S_RESET_PC;
            addr_reg <= '0;
            reg1 <= '0;
            psw.raw <= '0;
        end else begin
            if (xfer_ctl.pc_inc) pc <= pc + 1'b1;
            if (xfer_ctl.adl_write) addr_reg[7:0] <= mem_rdata;
            if (xfer_ctl.adh_write) addr_reg[15:8] <= mem_rdata;
            if (xfer_ctl.reg1_write) reg1 <= alu_y;
            // masked per-flag write
            psw.raw <= (psw.raw & ~alu_ctl.psw_write.raw)
                       | (psw_src_val & alu_ctl.psw_write.raw);
        end
    end

endmodule

// File: hw/s_step_top.sv
// ==========================================================
// one execution step: decoders plus execution unit
// state and instr come from an external sequencer
// ==========================================================

`timescale 1ns/1ps

`include "s_cpu_consts.svh"

module s_step_top (
    input  logic                 clk,
    input  logic                 reset,
    input  s_isa_pkg::state_e    state,
    input  s_isa_pkg::instr_e    instr,
    input  logic [`S_DATA_W-1:0] mem_rdata,
    output logic [`S_ADDR_W-1:0] mem_addr,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [`S_DATA_W-1:0] mem_wdata,
    output logic [`S_DATA_W-1:0] reg1,
    output s_isa_pkg::psw_word_u psw,
    output logic [`S_ADDR_W-1:0] pc
);

    s_ctl_pkg::xfer_ctl_t xfer_ctl;
    s_ctl_pkg::alu_ctl_t  alu_ctl;

    s_transfer_decoder u_xfer_dec (.state(state), .instr(instr), .xfer_ctl(xfer_ctl));
    s_alu_decoder u_alu_dec (.state(state), .instr(instr), .alu_ctl(alu_ctl));

    s_exec_unit u_exec (
        .clk       (clk),
        .reset     (reset),
        .xfer_ctl  (xfer_ctl),
        .alu_ctl   (alu_ctl),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .reg1      (reg1),
        .psw       (psw),
        .pc        (pc)
    );

endmodule

// File: sim/s_step_tb.sv
// ==========================================================
// self-checking testbench, the tb acts as the sequencer
// memory answers combinationally from mem_rdata
// ==========================================================

`timescale 1ns/1ps

`include "s_cpu_consts.svh"

module s_step_tb;

    logic                 clk;
    logic                 reset;
    s_isa_pkg::state_e    state;
    s_isa_pkg::instr_e    instr;
    logic [7:0]           mem_rdata;
    logic [15:0]          mem_addr;
    logic                 mem_read;
    logic                 mem_write;
    logic [7:0]           mem_wdata;
    logic [7:0]           reg1;
    s_isa_pkg::psw_word_u psw;
    logic [15:0]          pc;

    // reference model state and expected memory side
    logic [7:0]           m_reg1;
    s_isa_pkg::psw_word_u m_psw;
    logic [15:0]          m_pc;
    logic [15:0]          m_addr;
    logic [15:0]          exp_addr;
    logic                 exp_read;
    logic                 exp_write;
    logic [7:0]           exp_wdata;

    int                   err_reg1;
    int                   err_psw;
    int                   err_pc;
    int                   err_mem;
    int                   cycles;
    integer               seed;
    logic [31:0]          rnd;

    s_step_top DUT (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .reg1      (reg1),
        .psw       (psw),
        .pc        (pc)
    );

    always #4 clk = ~clk;

    // run limit, stimulus is about 630 cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 2000) begin
            $display("timeout: stimulus did not finish within 2000 cycles");
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ==========================================================
    // checks against the model
    // ==========================================================
    a_reg1: assert property (@(posedge clk) disable iff (reset) reg1 == m_reg1)
        else begin
            err_reg1++;
            $display("ERR reg1 dut=%h exp=%h", $sampled(reg1), $sampled(m_reg1));
        end

    a_psw: assert property (@(posedge clk) disable iff (reset) psw.raw == m_psw.raw)
        else begin
            err_psw++;
            $display("ERR psw dut=%h exp=%h", $sampled(psw.raw), $sampled(m_psw.raw));
        end

    a_pc: assert property (@(posedge clk) disable iff (reset) pc == m_pc)
        else begin
            err_pc++;
            $display("ERR pc dut=%h exp=%h", $sampled(pc), $sampled(m_pc));
        end

    a_read: assert property (@(posedge clk) disable iff (reset) mem_read == exp_read)
        else begin
            err_mem++;
            $display("ERR mem_read dut=%h exp=%h", $sampled(mem_read), $sampled(exp_read));
        end

    a_write: assert property (@(posedge clk) disable iff (reset) mem_write == exp_write)
        else begin
            err_mem++;
            $display("ERR mem_write dut=%h exp=%h", $sampled(mem_write),
                     $sampled(exp_write));
        end

    a_addr: assert property (@(posedge clk) disable iff (reset)
                             (exp_read || exp_write) |-> mem_addr == exp_addr)
        else begin
            err_mem++;
            $display("ERR mem_addr dut=%h exp=%h", $sampled(mem_addr), $sampled(exp_addr));
        end

    a_wdata: assert property (@(posedge clk) disable iff (reset)
                              exp_write |-> mem_wdata == exp_wdata)
        else begin
            err_mem++;
            $display("ERR mem_wdata dut=%h exp=%h", $sampled(mem_wdata),
                     $sampled(exp_wdata));
        end

    // accumulator result and flags for one instruction
    task automatic alu_model(input s_isa_pkg::instr_e ins, input logic [7:0] acc,
                             input logic [7:0] rd, input s_isa_pkg::psw_word_u p_in,
                             output logic [7:0] res, output s_isa_pkg::psw_word_u p_out);
        int full;
        int nib;
        int sa;
        int c;
        p_out = p_in;
        res = acc;
        c = p_in.f.c;
        case (ins)
            s_isa_pkg::SI_MOV: res = rd;
            s_isa_pkg::SI_ADC, s_isa_pkg::SI_ADD: begin
                if (ins == s_isa_pkg::SI_ADD) c = 0;
                full = int'(acc) + int'(rd) + c;
                nib = int'(acc[3:0]) + int'(rd[3:0]) + c;
                sa = int'($signed(acc)) + int'($signed(rd)) + c;
                res = full[7:0];
                p_out.f.c = (full > 255);
                p_out.f.h = (nib > 15);
                p_out.f.v = (sa > 127) || (sa < -128);
            end
            s_isa_pkg::SI_SBC, s_isa_pkg::SI_SUB, s_isa_pkg::SI_CMP: begin
                // borrow is the inverse of carry for SBC only
                c = (ins == s_isa_pkg::SI_SBC) ? 1 - c : 0;
                full = int'(acc) - int'(rd) - c;
                nib = int'(acc[3:0]) - int'(rd[3:0]) - c;
                sa = int'($signed(acc)) - int'($signed(rd)) - c;
                res = full[7:0];
                p_out.f.c = (full >= 0);
                if (ins != s_isa_pkg::SI_CMP) begin
                    p_out.f.h = (nib >= 0);
                    p_out.f.v = (sa > 127) || (sa < -128);
                end
            end
            s_isa_pkg::SI_AND: res = acc & rd;
            s_isa_pkg::SI_OR: res = acc | rd;
            s_isa_pkg::SI_EOR: res = acc ^ rd;
            s_isa_pkg::SI_INC: res = acc + 8'd1;
            s_isa_pkg::SI_DEC: res = acc - 8'd1;
            s_isa_pkg::SI_ASL, s_isa_pkg::SI_ROL: begin
                res = {acc[6:0], (ins == s_isa_pkg::SI_ROL) ? p_in.f.c : 1'b0};
                p_out.f.c = acc[7];
            end
            s_isa_pkg::SI_LSR, s_isa_pkg::SI_ROR: begin
                res = {(ins == s_isa_pkg::SI_ROR) ? p_in.f.c : 1'b0, acc[7:1]};
                p_out.f.c = acc[0];
            end
            default: ;
        endcase
        p_out.f.n = res[7];
        p_out.f.z = (res == 8'h00);
    endtask

    // drive one state, set expectations, advance the model on the edge
    task automatic apply_step(input s_isa_pkg::state_e st, input s_isa_pkg::instr_e ins,
                              input logic [7:0] rd);
        logic [7:0]           nxt_reg1;
        s_isa_pkg::psw_word_u nxt_psw;
        logic [15:0]          nxt_pc;
        logic [15:0]          nxt_addr;
        logic [15:0]          dp;
        logic [7:0]           res;
        state = st;
        instr = ins;
        mem_rdata = rd;
        nxt_reg1 = m_reg1;
        nxt_psw = m_psw;
        nxt_pc = m_pc;
        nxt_addr = m_addr;
        exp_read = 1'b0;
        exp_write = 1'b0;
        exp_addr = m_pc;
        exp_wdata = m_reg1;
        dp = {m_psw.f.p ? 8'h01 : 8'h00, m_addr[7:0]};
        case (st)
            s_isa_pkg::SS_ADLFETCH, s_isa_pkg::SS_ADHFETCH: begin
                exp_read = 1'b1;
                nxt_pc = m_pc + 16'd1;
                if (st == s_isa_pkg::SS_ADLFETCH) nxt_addr[7:0] = rd;
                else nxt_addr[15:8] = rd;
            end
            s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SS_CALC_REG1_MEMDP,
            s_isa_pkg::SS_CALC_REG1_MEMABS: begin
                exp_read = 1'b1;
                if (st == s_isa_pkg::SS_CALC_REG1_MEMPC) nxt_pc = m_pc + 16'd1;
                if (st == s_isa_pkg::SS_CALC_REG1_MEMDP) exp_addr = dp;
                if (st == s_isa_pkg::SS_CALC_REG1_MEMABS) exp_addr = m_addr;
                alu_model(ins, m_reg1, rd, m_psw, res, nxt_psw);
                if (ins != s_isa_pkg::SI_CMP) nxt_reg1 = res;
            end
            s_isa_pkg::SS_COPY_MEMDP_REG1: begin
                exp_write = 1'b1;
                exp_addr = dp;
            end
            s_isa_pkg::SS_CALC_REG1: begin
                alu_model(ins, m_reg1, 8'h00, m_psw, res, nxt_psw);
                nxt_reg1 = res;
            end
            s_isa_pkg::SS_XCN_REG1: begin
                nxt_reg1 = {m_reg1[3:0], m_reg1[7:4]};
                nxt_psw.f.n = nxt_reg1[7];
                nxt_psw.f.z = (nxt_reg1 == 8'h00);
            end
            s_isa_pkg::SS_PSW_CHANGE: begin
                case (ins)
                    s_isa_pkg::SI_CLRC: nxt_psw.f.c = 1'b0;
                    s_isa_pkg::SI_SETC: nxt_psw.f.c = 1'b1;
                    s_isa_pkg::SI_NOTC: nxt_psw.f.c = ~m_psw.f.c;
                    s_isa_pkg::SI_CLRV: {nxt_psw.f.v, nxt_psw.f.h} = 2'b00;
                    s_isa_pkg::SI_CLRP: nxt_psw.f.p = 1'b0;
                    s_isa_pkg::SI_SETP: nxt_psw.f.p = 1'b1;
                    s_isa_pkg::SI_EI: nxt_psw.f.i = 1'b1;
                    s_isa_pkg::SI_DI: nxt_psw.f.i = 1'b0;
                    default: ;
                endcase
            end
            default: ;
        endcase
        @(posedge clk);
        m_reg1 = nxt_reg1;
        m_psw = nxt_psw;
        m_pc = nxt_pc;
        m_addr = nxt_addr;
        #1;
    endtask

    // 7f + 01 overflows and carries out of bit 3
    task automatic set_v_and_h();
        apply_step(s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SI_MOV, 8'h7f);
        apply_step(s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SI_ADD, 8'h01);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        state = s_isa_pkg::SS_IDLE;
        instr = s_isa_pkg::SI_MOV;
        mem_rdata = 8'h00;
        m_reg1 = 8'h00;
        m_psw.raw = 8'h00;
        m_pc = `S_RESET_PC;
        m_addr = 16'h0000;
        exp_addr = 16'h0000;
        exp_read = 1'b0;
        exp_write = 1'b0;
        exp_wdata = 8'h00;
        err_reg1 = 0;
        err_psw = 0;
        err_pc = 0;
        err_mem = 0;
        cycles = 0;
        seed = 32'h71fe_be38;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset values with idle applied
        apply_step(s_isa_pkg::SS_IDLE, s_isa_pkg::SI_MOV, 8'h00);
        apply_step(s_isa_pkg::SS_IDLE, s_isa_pkg::SI_MOV, 8'h00);

        // immediate arithmetic, carry set at random first
        for (int k = 0; k < 80; k++) begin
            rnd = $random(seed);
            apply_step(s_isa_pkg::SS_PSW_CHANGE,
                       rnd[8] ? s_isa_pkg::SI_SETC : s_isa_pkg::SI_CLRC, 8'h00);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMPC,
                       s_isa_pkg::instr_e'(rnd[23:16] % 9), rnd[7:0]);
        end

        // address fetch then absolute operand
        for (int k = 0; k < 40; k++) begin
            rnd = $random(seed);
            apply_step(s_isa_pkg::SS_ADLFETCH, s_isa_pkg::SI_MOV, rnd[7:0]);
            apply_step(s_isa_pkg::SS_ADHFETCH, s_isa_pkg::SI_MOV, rnd[15:8]);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMABS,
                       s_isa_pkg::instr_e'(rnd[31:24] % 9), rnd[23:16]);
        end

        // direct page, page 1 then page 0
        for (int k = 0; k < 16; k++) begin
            rnd = $random(seed);
            apply_step(s_isa_pkg::SS_PSW_CHANGE, s_isa_pkg::SI_SETP, 8'h00);
            apply_step(s_isa_pkg::SS_ADLFETCH, s_isa_pkg::SI_MOV, rnd[7:0]);
            apply_step(s_isa_pkg::SS_COPY_MEMDP_REG1, s_isa_pkg::SI_MOV, 8'h00);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMDP,
                       s_isa_pkg::instr_e'(rnd[31:24] % 9), rnd[15:8]);
            apply_step(s_isa_pkg::SS_PSW_CHANGE, s_isa_pkg::SI_CLRP, 8'h00);
            apply_step(s_isa_pkg::SS_COPY_MEMDP_REG1, s_isa_pkg::SI_MOV, 8'h00);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMDP,
                       s_isa_pkg::instr_e'(rnd[27:20] % 9), rnd[23:16]);
        end

        // accumulator read-modify and nibble exchange
        for (int k = 0; k < 30; k++) begin
            rnd = $random(seed);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SI_MOV, rnd[7:0]);
            apply_step(s_isa_pkg::SS_PSW_CHANGE,
                       rnd[16] ? s_isa_pkg::SI_SETC : s_isa_pkg::SI_CLRC, 8'h00);
            apply_step(s_isa_pkg::SS_CALC_REG1,
                       s_isa_pkg::instr_e'(9 + rnd[31:24] % 6), 8'h00);
            apply_step(s_isa_pkg::SS_CALC_REG1_MEMPC, s_isa_pkg::SI_MOV, rnd[15:8]);
            apply_step(s_isa_pkg::SS_XCN_REG1, s_isa_pkg::SI_MOV, 8'h00);
        end

        // psw change, each one once and then in random order
        // v and h are set ahead of every CLRV
        for (int k = 15; k < 23; k++) begin
            if (k == 18) set_v_and_h();
            apply_step(s_isa_pkg::SS_PSW_CHANGE, s_isa_pkg::instr_e'(k), 8'h00);
        end
        for (int k = 0; k < 60; k++) begin
            rnd = $random(seed);
            if (rnd[10:8] == 3'd3) set_v_and_h();
            apply_step(s_isa_pkg::SS_PSW_CHANGE,
                       s_isa_pkg::instr_e'(15 + rnd[10:8] % 8), 8'h00);
        end

        // let the last updates reach the checks
        apply_step(s_isa_pkg::SS_IDLE, s_isa_pkg::SI_MOV, 8'h00);
        apply_step(s_isa_pkg::SS_IDLE, s_isa_pkg::SI_MOV, 8'h00);

        $display("errors: reg1 %0d psw %0d pc %0d mem %0d", err_reg1, err_psw, err_pc,
                 err_mem);
        if (err_reg1 + err_psw + err_pc + err_mem == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: spc700_step.f
+incdir+include
hw/s_isa_pkg.sv
hw/s_ctl_pkg.sv
hw/s_transfer_decoder.sv
hw/s_alu_decoder.sv
hw/s_alu.sv
hw/s_exec_unit.sv
hw/s_step_top.sv
sim/s_step_tb.sv
